/* dv/tb_checks.svh */
// Compare tasks for addresses, thread ids, masks, G port sources and bits, and the run stop

`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// Ends the run at the first error
task automatic stop_run(input string reason);
   $display("%s", reason);
   $display("STATUS: FAIL");
   $fatal(1, "Simulation stopped on the first error");
endtask

task automatic check_addr(input wb_pkg::reg_addr_t got, input wb_pkg::reg_addr_t exp,
                          input string what);
   if (got !== exp) begin
      stop_run($sformatf("FAIL %0t: %s is %0d, expected %0d", $time, what, got, exp));
   end
endtask

task automatic check_tid(input wb_pkg::tid_t got, input wb_pkg::tid_t exp, input string what);
   if (got !== exp) begin
      stop_run($sformatf("FAIL %0t: %s is %0d, expected %0d", $time, what, got, exp));
   end
endtask

task automatic check_mask(input wb_pkg::thr_mask_t got, input wb_pkg::thr_mask_t exp,
                          input string what);
   if (got !== exp) begin
      stop_run($sformatf("FAIL %0t: %s is %b, expected %b", $time, what, got, exp));
   end
endtask

task automatic check_src(input wb_pkg::g_src_e got, input wb_pkg::g_src_e exp,
                         input string what);
   if (got !== exp) begin
      stop_run($sformatf("FAIL %0t: %s is %0d, expected %0d", $time, what, got, exp));
   end
endtask

task automatic check_bit(input logic got, input logic exp, input string what);
   if (got !== exp) begin
      stop_run($sformatf("FAIL %0t: %s is %b, expected %b", $time, what, got, exp));
   end
endtask

`endif

/* dv/tb_exu_wb_ctl.sv */
// Directed testbench for the writeback control with clock, reset, LCG and the tests

`default_nettype none

module tb_exu_wb_ctl;

   localparam logic [31:0] LCG_SEED       = 32'h60e6_410c;
   localparam int          TIMEOUT_CYCLES = 20;
   localparam int          DRIVE_DELAY    = 2;

   logic              clk;
   logic              reset;
   logic              inst_wen_d;
   logic              kill_e;
   logic              restore_e;
   logic              return_d;
   logic              fill_e;
   logic              inst_vld_e;
   logic              kill_m;
   wb_pkg::reg_addr_t rd_m;
   wb_pkg::tid_t      tid_m;
   wb_pkg::thr_mask_t thr_m;
   logic              flush_w;
   logic              inst_vld_w;
   logic              flush_w1;
   wb_pkg::tid_t      tid_w1;
   logic              ld_vld_g;
   wb_pkg::reg_addr_t ld_rd_g;
   wb_pkg::tid_t      ld_tid_g;
   logic              ldst_miss_g2;
   logic              muldiv_valid;
   wb_pkg::reg_addr_t muldiv_rd;
   wb_pkg::tid_t      muldiv_tid;
   logic              muldiv_setcc;
   logic              muldiv_ready;
   logic              rmlop_done_e;
   wb_pkg::thr_mask_t swap_done;
   logic              wb_e;
   logic              sel_pipe_m;
   logic              sel_load_m;
   logic              sel_restore_m;
   wb_pkg::reg_addr_t irf_rd_m;
   wb_pkg::tid_t      irf_tid_m;
   logic              irf_wen_w;
   wb_pkg::g_src_e    g_src;
   logic              irf_wen_g;
   wb_pkg::reg_addr_t irf_rd_g;
   wb_pkg::tid_t      irf_tid_g;
   logic              irf_wen_w2;
   wb_pkg::reg_addr_t irf_rd_w2;
   wb_pkg::tid_t      irf_tid_w2;
   logic              setcc_g;
   wb_pkg::thr_mask_t longop_done_g;
   logic [31:0]       lcg_state;

   exu_wb_ctl dut_i (.*);

   `include "tb_checks.svh"

   initial begin
      clk = 1'b0;
      forever begin
         #10 clk = ~clk;
      end
   end

   ////////////////////
   // Stimulus helpers
   ////////////////////
   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic wb_pkg::reg_addr_t rand_addr();
      logic [31:0] r;
      r = lcg_next();
      return r[31:27];
   endfunction

   function automatic wb_pkg::tid_t rand_tid();
      logic [31:0] r;
      r = lcg_next();
      return r[30:29];
   endfunction

   function automatic wb_pkg::thr_mask_t rand_mask();
      logic [31:0] r;
      r = lcg_next();
      return r[27:24];
   endfunction

   task automatic idle_inputs();
      inst_wen_d   = 1'b0;
      kill_e       = 1'b0;
      restore_e    = 1'b0;
      return_d     = 1'b0;
      fill_e       = 1'b0;
      inst_vld_e   = 1'b1;
      kill_m       = 1'b0;
      rd_m         = '0;
      tid_m        = '0;
      thr_m        = '0;
      flush_w      = 1'b0;
      inst_vld_w   = 1'b1;
      flush_w1     = 1'b0;
      tid_w1       = '0;
      ld_vld_g     = 1'b0;
      ld_rd_g      = '0;
      ld_tid_g     = '0;
      ldst_miss_g2 = 1'b0;
      muldiv_valid = 1'b0;
      muldiv_rd    = '0;
      muldiv_tid   = '0;
      muldiv_setcc = 1'b0;
      rmlop_done_e = 1'b0;
      swap_done    = '0;
   endtask

   // Inputs change shortly after the rising edge and start from idle each cycle
   task automatic begin_cycle();
      @(posedge clk);
      #DRIVE_DELAY;
      idle_inputs();
   endtask

   task automatic to_sample_point();
      @(negedge clk);
   endtask

   task automatic drain(input int cycles);
      repeat (cycles) begin
         begin_cycle();
         to_sample_point();
      end
   endtask

   task automatic hold_muldiv(input wb_pkg::reg_addr_t rd, input wb_pkg::tid_t tid,
                              input logic setcc);
      muldiv_valid = 1'b1;
      muldiv_rd    = rd;
      muldiv_tid   = tid;
      muldiv_setcc = setcc;
   endtask

   ////////////////////
   // Directed tests
   ////////////////////
   task automatic check_reset_state();
      check_bit(wb_e, 1'b0, "wb_e after reset");
      check_bit(irf_wen_w, 1'b0, "irf_wen_w after reset");
      check_bit(irf_wen_g, 1'b0, "irf_wen_g after reset");
      check_bit(irf_wen_w2, 1'b0, "irf_wen_w2 after reset");
      check_bit(sel_load_m, 1'b0, "sel_load_m after reset");
      check_bit(setcc_g, 1'b0, "setcc_g after reset");
      check_mask(longop_done_g, '0, "longop_done_g after reset");
      check_bit(muldiv_ready, 1'b1, "muldiv_ready after reset");
   endtask

   // Kill stage 0 is none, 1 to 3 kill in E, M or W
   task automatic pipe_write(input int kill_stage);
      wb_pkg::reg_addr_t rd;
      wb_pkg::tid_t      tid;
      rd  = rand_addr();
      tid = rand_tid();
      begin_cycle();
      inst_wen_d = 1'b1;
      to_sample_point();
      begin_cycle();
      kill_e = (kill_stage == 1);
      to_sample_point();
      check_bit(wb_e, 1'b1, "wb_e one cycle after inst_wen_d");
      check_bit(irf_wen_w, 1'b0, "irf_wen_w in E");
      begin_cycle();
      kill_m = (kill_stage == 2);
      rd_m   = rd;
      tid_m  = tid;
      to_sample_point();
      check_bit(sel_pipe_m, kill_stage != 1, "sel_pipe_m in M");
      if (kill_stage != 1) begin
         check_addr(irf_rd_m, rd, "irf_rd_m from the pipe");
         check_tid(irf_tid_m, tid, "irf_tid_m from the pipe");
      end
      check_bit(irf_wen_w, 1'b0, "irf_wen_w in M");
      begin_cycle();
      flush_w = (kill_stage == 3);
      to_sample_point();
      check_bit(irf_wen_w, kill_stage == 0, "irf_wen_w in W");
      begin_cycle();
      to_sample_point();
      check_bit(irf_wen_w, 1'b0, "irf_wen_w after W");
   endtask

   // Mode 0 plain, 1 miss, 2 flush on its thread, 3 flush on another thread
   task automatic load_on_w1(input int mode);
      wb_pkg::reg_addr_t rd;
      wb_pkg::tid_t      tid;
      rd  = rand_addr();
      tid = rand_tid();
      begin_cycle();
      ld_vld_g = 1'b1;
      ld_rd_g  = rd;
      ld_tid_g = tid;
      to_sample_point();
      begin_cycle();
      ldst_miss_g2 = (mode == 1);
      flush_w1     = (mode >= 2);
      tid_w1       = (mode == 3) ? tid + 2'd1 : tid;
      to_sample_point();
      check_bit(sel_load_m, 1'b1, "sel_load_m for a lone load");
      check_addr(irf_rd_m, rd, "irf_rd_m for a lone load");
      check_tid(irf_tid_m, tid, "irf_tid_m for a lone load");
      check_bit(irf_wen_g, 1'b0, "irf_wen_g for a lone load");
      begin_cycle();
      to_sample_point();
      check_bit(irf_wen_w, (mode == 0) || (mode == 3), "irf_wen_w for a lone load");
   endtask

   task automatic load_on_g();
      wb_pkg::reg_addr_t rd;
      wb_pkg::tid_t      tid;
      rd  = rand_addr();
      tid = rand_tid();
      begin_cycle();
      inst_wen_d = 1'b1;
      to_sample_point();
      begin_cycle();
      ld_vld_g = 1'b1;
      ld_rd_g  = rd;
      ld_tid_g = tid;
      to_sample_point();
      // Pipe reaches M while the load sits in G2
      begin_cycle();
      to_sample_point();
      check_bit(sel_pipe_m, 1'b1, "sel_pipe_m beside a load");
      check_bit(sel_load_m, 1'b0, "sel_load_m beside the pipe");
      check_src(g_src, wb_pkg::G_LOAD, "g_src for a load on G");
      check_bit(irf_wen_g, 1'b1, "irf_wen_g for a load on G");
      check_addr(irf_rd_g, rd, "irf_rd_g for a load on G");
      check_tid(irf_tid_g, tid, "irf_tid_g for a load on G");
      check_bit(muldiv_ready, 1'b0, "muldiv_ready while a load holds G");
      begin_cycle();
      to_sample_point();
      check_bit(irf_wen_w2, 1'b1, "irf_wen_w2 for a load on G");
      check_addr(irf_rd_w2, rd, "irf_rd_w2 for a load on G");
      check_tid(irf_tid_w2, tid, "irf_tid_w2 for a load on G");
      check_bit(irf_wen_w, 1'b1, "irf_wen_w of the pipe write");
   endtask

   task automatic muldiv_behind_loads(input logic setcc);
      wb_pkg::reg_addr_t mrd;
      wb_pkg::tid_t      mtid;
      wb_pkg::thr_mask_t exp_done;
      int                cyc;
      int                waited;
      mrd      = rand_addr();
      mtid     = rand_tid();
      exp_done = '0;
      exp_done[mtid] = 1'b1;
      // Three pipe writes meet three loads, so G is taken for three cycles
      for (cyc = 0; cyc < 5; cyc++) begin
         begin_cycle();
         inst_wen_d = (cyc < 3);
         ld_vld_g   = (cyc >= 1) && (cyc < 4);
         ld_rd_g    = rand_addr();
         ld_tid_g   = rand_tid();
         if (cyc >= 2) begin
            hold_muldiv(mrd, mtid, setcc);
         end
         to_sample_point();
         if (cyc >= 2) begin
            check_bit(muldiv_ready, 1'b0, "muldiv_ready while loads hold G");
            check_src(g_src, wb_pkg::G_LOAD, "g_src while loads hold G");
            check_bit(irf_wen_g, 1'b1, "irf_wen_g for a load ahead of mul/div");
         end
      end
      begin_cycle();
      hold_muldiv(mrd, mtid, setcc);
      to_sample_point();
      waited = 0;
      while (muldiv_ready !== 1'b1) begin
         if (waited == TIMEOUT_CYCLES) begin
            stop_run("Timeout: muldiv_ready stayed low after the loads drained");
         end
         begin_cycle();
         hold_muldiv(mrd, mtid, setcc);
         to_sample_point();
         waited++;
      end
      check_src(g_src, wb_pkg::G_MULDIV, "g_src on the mul/div transfer");
      check_bit(irf_wen_g, 1'b1, "irf_wen_g on the mul/div transfer");
      check_addr(irf_rd_g, mrd, "irf_rd_g on the mul/div transfer");
      check_tid(irf_tid_g, mtid, "irf_tid_g on the mul/div transfer");
      check_bit(setcc_g, setcc, "setcc_g on the mul/div transfer");
      check_mask(longop_done_g, exp_done, "longop_done_g on the mul/div transfer");
      begin_cycle();
      to_sample_point();
      check_bit(irf_wen_w2, 1'b1, "irf_wen_w2 after the mul/div transfer");
      check_addr(irf_rd_w2, mrd, "irf_rd_w2 after the mul/div transfer");
      check_tid(irf_tid_w2, mtid, "irf_tid_w2 after the mul/div transfer");
      check_mask(longop_done_g, '0, "longop_done_g after the mul/div transfer");
   endtask

   // Mode 0 W1 free, 1 pipe holds W1, 2 pipe and load hold both ports, 3 flushed in W
   task automatic restore_write(input int mode);
      wb_pkg::reg_addr_t rd;
      wb_pkg::tid_t      tid;
      wb_pkg::thr_mask_t exp_done;
      int                waited;
      rd       = rand_addr();
      tid      = rand_tid();
      exp_done = '0;
      exp_done[tid] = 1'b1;
      begin_cycle();
      inst_wen_d = 1'b1;
      to_sample_point();
      begin_cycle();
      restore_e  = 1'b1;
      inst_wen_d = (mode == 1) || (mode == 2);
      to_sample_point();
      // Restore in M, destination captured here
      begin_cycle();
      rd_m     = rd;
      tid_m    = tid;
      ld_vld_g = (mode == 2);
      ld_rd_g  = rand_addr();
      ld_tid_g = rand_tid();
      to_sample_point();
      begin_cycle();
      flush_w = (mode == 3);
      to_sample_point();
      if (mode == 3) begin
         check_mask(longop_done_g, '0, "longop_done_g for a flushed restore");
         check_bit(irf_wen_g, 1'b0, "irf_wen_g for a flushed restore");
         repeat (2) begin
            begin_cycle();
            to_sample_point();
            check_bit(irf_wen_w, 1'b0, "irf_wen_w for a flushed restore");
            check_mask(longop_done_g, '0, "longop_done_g for a flushed restore");
         end
      end else begin
         waited = 0;
         while (longop_done_g === '0) begin
            if (waited == TIMEOUT_CYCLES) begin
               stop_run("Timeout: the restore done bit never appeared");
            end
            begin_cycle();
            to_sample_point();
            waited++;
         end
         check_mask(longop_done_g, exp_done, "restore done bit");
         check_bit(waited == ((mode == 2) ? 1 : 0), 1'b1, "restore pick in the expected cycle");
         if (mode == 1) begin
            check_src(g_src, wb_pkg::G_RESTORE, "g_src for a restore on G");
            check_bit(irf_wen_g, 1'b1, "irf_wen_g for a restore on G");
            check_addr(irf_rd_g, rd, "irf_rd_g for a restore on G");
            check_tid(irf_tid_g, tid, "irf_tid_g for a restore on G");
         end else begin
            check_bit(sel_restore_m, 1'b1, "sel_restore_m for a restore on W1");
            check_addr(irf_rd_m, rd, "irf_rd_m for a restore on W1");
            check_tid(irf_tid_m, tid, "irf_tid_m for a restore on W1");
            begin_cycle();
            to_sample_point();
            check_bit(irf_wen_w, 1'b1, "irf_wen_w for a restore on W1");
         end
      end
   endtask

   task automatic short_longop_done(input logic kill);
      wb_pkg::thr_mask_t thr;
      wb_pkg::thr_mask_t swap0;
      wb_pkg::thr_mask_t swap1;
      wb_pkg::thr_mask_t exp_done;
      thr      = rand_mask();
      swap0    = rand_mask();
      swap1    = rand_mask();
      exp_done = swap1;
      if (!kill) begin
         exp_done = exp_done | thr;
      end
      begin_cycle();
      rmlop_done_e = 1'b1;
      swap_done    = swap0;
      to_sample_point();
      check_mask(longop_done_g, swap0, "longop_done_g with only a swap done");
      begin_cycle();
      thr_m     = thr;
      kill_m    = kill;
      swap_done = swap1;
      to_sample_point();
      check_mask(longop_done_g, exp_done, "longop_done_g after rmlop_done_e");
      begin_cycle();
      to_sample_point();
      check_mask(longop_done_g, '0, "longop_done_g after the short done");
   endtask

   ////////////////////
   // Test sequence
   ////////////////////
   initial begin
      int mode;
      lcg_state = LCG_SEED;
      idle_inputs();
      reset = 1'b1;
      repeat (16) begin
         @(posedge clk);
      end
      #DRIVE_DELAY;
      reset = 1'b0;
      to_sample_point();
      check_reset_state();
      for (mode = 0; mode < 4; mode++) begin
         pipe_write(mode);
         drain(3);
      end
      for (mode = 0; mode < 4; mode++) begin
         load_on_w1(mode);
         drain(3);
      end
      repeat (2) begin
         load_on_g();
         drain(3);
      end
      muldiv_behind_loads(1'b1);
      drain(3);
      muldiv_behind_loads(1'b0);
      drain(3);
      for (mode = 0; mode < 4; mode++) begin
         restore_write(mode);
         drain(3);
      end
      short_longop_done(1'b0);
      short_longop_done(1'b1);
      drain(2);
      $display("STATUS: PASS");
      $finish;
   end

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# Build the writeback control testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

log_file=sim.log

if ! verilator --binary -f src.f --top-module tb_exu_wb_ctl -Mdir obj_dir -o tb_exu_wb_ctl; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/tb_exu_wb_ctl > "$log_file" 2>&1
sim_status=$?

if ! cat "$log_file"; then
   echo "Could not read $log_file"
   exit 1
fi

if grep -q "STATUS: FAIL" "$log_file"; then
   echo "Simulation reported a failure"
   exit 1
fi

if [ "$sim_status" -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
   exit 1
fi

exit 0

/* src.f */
+incdir+dv
verilog/wb_pkg.sv
verilog/wb_pipe_valid.sv
verilog/wb_load_stage.sv
verilog/wb_restore_tracker.sv
verilog/wb_port_arbiter.sv
verilog/wb_longop_done.sv
verilog/exu_wb_ctl.sv
dv/tb_exu_wb_ctl.sv

/* verilog/exu_wb_ctl.sv */
// Writeback control top level joining the trackers, the port arbiter and completion

`default_nettype none

module exu_wb_ctl (
   input  wire logic              clk,
   input  wire logic              reset,
   // Pipeline
   input  wire logic              inst_wen_d,
   input  wire logic              kill_e,
   input  wire logic              restore_e,
   input  wire logic              return_d,
   input  wire logic              fill_e,
   input  wire logic              inst_vld_e,
   input  wire logic              kill_m,
   input  wire wb_pkg::reg_addr_t rd_m,
   input  wire wb_pkg::tid_t      tid_m,
   input  wire wb_pkg::thr_mask_t thr_m,
   input  wire logic              flush_w,
   input  wire logic              inst_vld_w,
   input  wire logic              flush_w1,
   input  wire wb_pkg::tid_t      tid_w1,
   // Load return
   input  wire logic              ld_vld_g,
   input  wire wb_pkg::reg_addr_t ld_rd_g,
   input  wire wb_pkg::tid_t      ld_tid_g,
   input  wire logic              ldst_miss_g2,
   // Mul/div request
   input  wire logic              muldiv_valid,
   input  wire wb_pkg::reg_addr_t muldiv_rd,
   input  wire wb_pkg::tid_t      muldiv_tid,
   input  wire logic              muldiv_setcc,
   output logic                   muldiv_ready,
   // Other completions
   input  wire logic              rmlop_done_e,
   input  wire wb_pkg::thr_mask_t swap_done,
   // Register file W1 port
   output logic                   wb_e,
   output logic                   sel_pipe_m,
   output logic                   sel_load_m,
   output logic                   sel_restore_m,
   output wb_pkg::reg_addr_t      irf_rd_m,
   output wb_pkg::tid_t           irf_tid_m,
   output logic                   irf_wen_w,
   // Register file G port
   output wb_pkg::g_src_e         g_src,
   output logic                   irf_wen_g,
   output wb_pkg::reg_addr_t      irf_rd_g,
   output wb_pkg::tid_t           irf_tid_g,
   output logic                   irf_wen_w2,
   output wb_pkg::reg_addr_t      irf_rd_w2,
   output wb_pkg::tid_t           irf_tid_w2,
   output logic                   setcc_g,
   output wb_pkg::thr_mask_t      longop_done_g
);

   logic              wb_m;
   logic              pipe_wen_w;
   logic              w1_nopipe_wen_w;
   logic              ld_busy_g2;
   logic              ld_wen_g2;
   wb_pkg::reg_addr_t ld_rd_g2;
   wb_pkg::tid_t      ld_tid_g2;
   logic              return_e;
   logic              restore_request;
   logic              restore_wen;
   wb_pkg::reg_addr_t restore_rd;
   wb_pkg::tid_t      restore_tid;
   wb_pkg::thr_mask_t restore_done;
   logic              restore_picked;
   wb_pkg::thr_mask_t muldiv_done_g;

   wb_pipe_valid u_pipe_valid (
      .clk, .reset, .inst_wen_d, .kill_e, .restore_e, .kill_m, .flush_w, .inst_vld_w,
      .wb_e, .wb_m, .pipe_wen_w
   );

   wb_load_stage u_load_stage (
      .clk, .reset, .ld_vld_g, .ld_rd_g, .ld_tid_g, .ldst_miss_g2, .flush_w1, .tid_w1,
      .ld_busy_g2, .ld_wen_g2, .ld_rd_g2, .ld_tid_g2
   );

   // The E write enable of the pipe qualifies the restore
   wb_restore_tracker u_restore_tracker (
      .clk, .reset, .restore_e, .inst_wen_e(wb_e), .return_d, .fill_e, .inst_vld_e,
      .rd_m, .tid_m, .flush_w, .inst_vld_w, .restore_picked,
      .return_e, .restore_request, .restore_wen, .restore_rd, .restore_tid, .restore_done
   );

   wb_port_arbiter u_port_arbiter (
      .clk, .reset, .wb_m, .rd_m, .tid_m,
      .ld_busy_g2, .ld_wen_g2, .ld_rd_g2, .ld_tid_g2,
      .restore_request, .restore_wen, .restore_rd, .restore_tid,
      .muldiv_valid, .muldiv_rd, .muldiv_tid, .muldiv_setcc,
      .sel_pipe_m, .sel_load_m, .sel_restore_m, .irf_rd_m, .irf_tid_m, .w1_nopipe_wen_w,
      .g_src, .irf_wen_g, .irf_rd_g, .irf_tid_g, .irf_wen_w2, .irf_rd_w2, .irf_tid_w2,
      .muldiv_ready, .setcc_g, .muldiv_done_g, .restore_picked
   );

   wb_longop_done u_longop_done (
      .clk, .reset, .rmlop_done_e, .restore_e, .inst_wen_e(wb_e), .return_e, .inst_vld_e,
      .kill_e, .thr_m, .kill_m, .muldiv_done_g, .restore_done, .swap_done,
      .longop_done_g
   );

   // W1 write from the pipe or from a load or restore
   assign irf_wen_w = pipe_wen_w | w1_nopipe_wen_w;

endmodule

`default_nettype wire

/* verilog/wb_load_stage.sv */
// Load return register stage with kill on miss and on a thread flush

`default_nettype none

module wb_load_stage (
   input  wire logic              clk,
   input  wire logic              reset,
   input  wire logic              ld_vld_g,
   input  wire wb_pkg::reg_addr_t ld_rd_g,
   input  wire wb_pkg::tid_t      ld_tid_g,
   input  wire logic              ldst_miss_g2,
   input  wire logic              flush_w1,
   input  wire wb_pkg::tid_t      tid_w1,
   output logic                   ld_busy_g2,
   output logic                   ld_wen_g2,
   output wb_pkg::reg_addr_t      ld_rd_g2,
   output wb_pkg::tid_t           ld_tid_g2
);

   logic kill_ld_g2;

   // Return valid, claims a port whether or not it is killed
   always_ff @(posedge clk) begin
      if (reset) begin
         ld_busy_g2 <= 1'b0;
      end else begin
         ld_busy_g2 <= ld_vld_g;
      end
   end

   always_ff @(posedge clk) begin
      ld_rd_g2  <= ld_rd_g;
      ld_tid_g2 <= ld_tid_g;
   end

   // Flush only hits the load of the same thread
   assign kill_ld_g2 = flush_w1 & (ld_tid_g2 == tid_w1);
   assign ld_wen_g2  = ld_busy_g2 & ~kill_ld_g2 & ~ldst_miss_g2;

endmodule

`default_nettype wire

/* verilog/wb_longop_done.sv */
// Per-thread completion mask for long operations

`default_nettype none

module wb_longop_done (
   input  wire logic              clk,
   input  wire logic              reset,
   input  wire logic              rmlop_done_e,
   input  wire logic              restore_e,
   input  wire logic              inst_wen_e,
   input  wire logic              return_e,
   input  wire logic              inst_vld_e,
   input  wire logic              kill_e,
   input  wire wb_pkg::thr_mask_t thr_m,
   input  wire logic              kill_m,
   input  wire wb_pkg::thr_mask_t muldiv_done_g,
   input  wire wb_pkg::thr_mask_t restore_done,
   input  wire wb_pkg::thr_mask_t swap_done,
   output wb_pkg::thr_mask_t      longop_done_g
);

   logic              short_done_e;
   logic              short_done_m;
   wb_pkg::thr_mask_t short_done;

   // A restore without a register write finishes right away
   // Instruction valid guards against a stray completion
   assign short_done_e = (rmlop_done_e | (restore_e & ~inst_wen_e & ~return_e))
                         & inst_vld_e & ~kill_e;

   always_ff @(posedge clk) begin
      if (reset) begin
         short_done_m <= 1'b0;
      end else begin
         short_done_m <= short_done_e;
      end
   end

   assign short_done = thr_m & {wb_pkg::NUM_THREADS{short_done_m & ~kill_m}};

   ////////////////////
   // Merge
   ////////////////////
   assign longop_done_g = muldiv_done_g | restore_done | short_done | swap_done;

endmodule

`default_nettype wire

/* verilog/wb_pipe_valid.sv */
// Pipeline write-enable tracking from D to W with per-stage kills

`default_nettype none

module wb_pipe_valid (
   input  wire logic clk,
   input  wire logic reset,
   input  wire logic inst_wen_d,
   input  wire logic kill_e,
   input  wire logic restore_e,
   input  wire logic kill_m,
   input  wire logic flush_w,
   input  wire logic inst_vld_w,
   output logic      wb_e,
   output logic      wb_m,
   output logic      pipe_wen_w
);

   logic valid_e;
   logic valid_m;
   logic wb_w;

   // A restore cannot complete in the pipe, so its E write is dropped
   assign valid_e = wb_e & ~kill_e & ~restore_e;
   assign valid_m = wb_m & ~kill_m;

   ////////////////////
   // Stage registers
   ////////////////////
   always_ff @(posedge clk) begin
      if (reset) begin
         wb_e <= 1'b0;
         wb_m <= 1'b0;
         wb_w <= 1'b0;
      end else begin
         wb_e <= inst_wen_d;
         wb_m <= valid_e;
         wb_w <= valid_m;
      end
   end

   // Late flush and instruction valid are checked in W
   assign pipe_wen_w = wb_w & ~flush_w & inst_vld_w;

endmodule

`default_nettype wire

/* verilog/wb_pkg.sv */
// Shared register, thread and G port source types for the writeback control

`default_nettype none

package wb_pkg;

   // Fixed thread count of the core
   localparam int NUM_THREADS = 4;

   // Register file destination index
   typedef logic [4:0] reg_addr_t;

   // Thread id
   typedef logic [1:0] tid_t;

   // Per-thread mask, one bit per thread
   typedef logic [NUM_THREADS-1:0] thr_mask_t;

   // Source driving the G write port
   typedef enum logic [1:0] {
      G_LOAD    = 2'd0,
      G_RESTORE = 2'd1,
      G_MULDIV  = 2'd2
   } g_src_e;

   // One-hot thread decode
   function automatic thr_mask_t tid_to_mask(input tid_t tid);
      thr_mask_t mask;
      mask = '0;
      mask[tid] = 1'b1;
      return mask;
   endfunction

endpackage

`default_nettype wire

/* verilog/wb_port_arbiter.sv */
// W1 and G port source selection, mul/div handshake and the G to W2 register

`default_nettype none

module wb_port_arbiter (
   input  wire logic              clk,
   input  wire logic              reset,
   input  wire logic              wb_m,
   input  wire wb_pkg::reg_addr_t rd_m,
   input  wire wb_pkg::tid_t      tid_m,
   input  wire logic              ld_busy_g2,
   input  wire logic              ld_wen_g2,
   input  wire wb_pkg::reg_addr_t ld_rd_g2,
   input  wire wb_pkg::tid_t      ld_tid_g2,
   input  wire logic              restore_request,
   input  wire logic              restore_wen,
   input  wire wb_pkg::reg_addr_t restore_rd,
   input  wire wb_pkg::tid_t      restore_tid,
   input  wire logic              muldiv_valid,
   input  wire wb_pkg::reg_addr_t muldiv_rd,
   input  wire wb_pkg::tid_t      muldiv_tid,
   input  wire logic              muldiv_setcc,
   output logic                   sel_pipe_m,
   output logic                   sel_load_m,
   output logic                   sel_restore_m,
   output wb_pkg::reg_addr_t      irf_rd_m,
   output wb_pkg::tid_t           irf_tid_m,
   output logic                   w1_nopipe_wen_w,
   output wb_pkg::g_src_e         g_src,
   output logic                   irf_wen_g,
   output wb_pkg::reg_addr_t      irf_rd_g,
   output wb_pkg::tid_t           irf_tid_g,
   output logic                   irf_wen_w2,
   output wb_pkg::reg_addr_t      irf_rd_w2,
   output wb_pkg::tid_t           irf_tid_w2,
   output logic                   muldiv_ready,
   output logic                   setcc_g,
   output wb_pkg::thr_mask_t      muldiv_done_g,
   output logic                   restore_picked
);

   logic sel_load_g;
   logic sel_restore_g;
   logic muldiv_xfer;
   logic w1_nopipe_wen_m;

   ////////////////////
   // W1 port
   ////////////////////
   assign sel_pipe_m    = wb_m;
   assign sel_load_m    = ~wb_m & ld_busy_g2;
   assign sel_restore_m = ~wb_m & ~ld_busy_g2;

   assign irf_rd_m  = sel_pipe_m ? rd_m  : (sel_load_m ? ld_rd_g2  : restore_rd);
   assign irf_tid_m = sel_pipe_m ? tid_m : (sel_load_m ? ld_tid_g2 : restore_tid);

   // Load and restore writes skip the W stage checks of the pipe
   assign w1_nopipe_wen_m = (sel_load_m & ld_wen_g2) | (sel_restore_m & restore_wen);

   ////////////////////
   // G port
   ////////////////////
   // Priority load, restore, mul/div
   assign sel_load_g    = ld_busy_g2 & wb_m;
   assign sel_restore_g = restore_request & (wb_m ^ ld_busy_g2);
   assign muldiv_ready  = ~(sel_load_g | sel_restore_g);
   assign muldiv_xfer   = muldiv_valid & muldiv_ready;

   always_comb begin
      if (sel_load_g) begin
         g_src = wb_pkg::G_LOAD;
      end else if (sel_restore_g) begin
         g_src = wb_pkg::G_RESTORE;
      end else begin
         g_src = wb_pkg::G_MULDIV;
      end
   end

   always_comb begin
      case (g_src)
         wb_pkg::G_LOAD: begin
            irf_rd_g  = ld_rd_g2;
            irf_tid_g = ld_tid_g2;
         end
         wb_pkg::G_RESTORE: begin
            irf_rd_g  = restore_rd;
            irf_tid_g = restore_tid;
         end
         default: begin
            irf_rd_g  = muldiv_rd;
            irf_tid_g = muldiv_tid;
         end
      endcase
   end

   assign irf_wen_g = (sel_load_g & ld_wen_g2) | (sel_restore_g & restore_wen) | muldiv_xfer;

   // Condition codes only change on an accepted mul/div
   assign setcc_g       = muldiv_xfer & muldiv_setcc;
   assign muldiv_done_g = wb_pkg::tid_to_mask(muldiv_tid)
                          & {wb_pkg::NUM_THREADS{muldiv_xfer}};

   assign restore_picked = restore_request & (sel_restore_m | sel_restore_g);

   ////////////////////
   // W and W2 registers
   ////////////////////
   always_ff @(posedge clk) begin
      if (reset) begin
         w1_nopipe_wen_w <= 1'b0;
         irf_wen_w2      <= 1'b0;
      end else begin
         w1_nopipe_wen_w <= w1_nopipe_wen_m;
         irf_wen_w2      <= irf_wen_g;
      end
   end

   always_ff @(posedge clk) begin
      irf_rd_w2  <= irf_rd_g;
      irf_tid_w2 <= irf_tid_g;
   end

endmodule

`default_nettype wire

/* verilog/wb_restore_tracker.sv */
// Restore pipeline from E to W, pending flag, captured destination and done pulse

`default_nettype none

module wb_restore_tracker (
   input  wire logic              clk,
   input  wire logic              reset,
   input  wire logic              restore_e,
   input  wire logic              inst_wen_e,
   input  wire logic              return_d,
   input  wire logic              fill_e,
   input  wire logic              inst_vld_e,
   input  wire wb_pkg::reg_addr_t rd_m,
   input  wire wb_pkg::tid_t      tid_m,
   input  wire logic              flush_w,
   input  wire logic              inst_vld_w,
   input  wire logic              restore_picked,
   output logic                   return_e,
   output logic                   restore_request,
   output logic                   restore_wen,
   output wb_pkg::reg_addr_t      restore_rd,
   output wb_pkg::tid_t           restore_tid,
   output wb_pkg::thr_mask_t      restore_done
);

   logic vld_restore_e;
   logic restore_m;
   logic restore_w;
   logic vld_restore_w;
   logic restore_pending;
   logic pending_next;

   // Returns switch the window back on their own and need no tracking
   assign vld_restore_e = restore_e & inst_wen_e & ~return_e & ~fill_e & inst_vld_e;

   ////////////////////
   // Restore pipe
   ////////////////////
   always_ff @(posedge clk) begin
      if (reset) begin
         return_e        <= 1'b0;
         restore_m       <= 1'b0;
         restore_w       <= 1'b0;
         restore_pending <= 1'b0;
      end else begin
         return_e        <= return_d;
         restore_m       <= vld_restore_e;
         restore_w       <= restore_m;
         restore_pending <= pending_next;
      end
   end

   // Destination is taken while the restore sits in M
   always_ff @(posedge clk) begin
      if (restore_m) begin
         restore_rd  <= rd_m;
         restore_tid <= tid_m;
      end
   end

   // A restore in W claims a port even before its flush is known
   assign vld_restore_w   = restore_w & ~flush_w & inst_vld_w;
   assign restore_request = restore_w | restore_pending;
   assign restore_wen     = vld_restore_w | restore_pending;

   // Wait until some port takes the write
   assign pending_next = (vld_restore_w | restore_pending) & ~restore_picked;

   assign restore_done = wb_pkg::tid_to_mask(restore_tid)
                         & {wb_pkg::NUM_THREADS{restore_picked & restore_wen}};

endmodule

`default_nettype wire
